//--- hdl/chan_config.svh
`ifndef CHAN_CONFIG_SVH
`define CHAN_CONFIG_SVH

// channel count and data widths
`define NCHAN           4
`define SMP_W           12     // raw adc sample
`define WORD_W          16     // output stream word

// fifo depths in words
`define CHAN_FIFO_DEPTH 8
`define TRIG_FIFO_DEPTH 4

// register port
`define REG_ADR_W       4
`define REG_ZTHR        0      // zero suppression threshold, signed
`define REG_STHR        1      // sum trigger threshold, signed
`define REG_MASK        2      // channel enable mask
`define REG_INV         3      // per channel inversion
`define REG_PED0        4      // pedestals, one per channel from here
`define REG_STAT        15     // sticky overflow bits, clear on read

`endif

//--- hdl/chan_pkg.sv
`default_nettype none

`include "chan_config.svh"

package chan_pkg;

	// raw adc sample, unsigned
	typedef logic [`SMP_W-1:0] sample_t;

	// pedestal subtracted value, one bit wider and signed
	typedef logic signed [`SMP_W:0] diff_t;

	// one word of the output stream
	typedef logic [`WORD_W-1:0] word_t;

	// channel data word as it leaves the fifo
	typedef struct packed {
		logic [2:0] chan;   // source channel
		diff_t      diff;   // pedestal subtracted sample
	} chan_word_t;

	// trigger record, sample count since reset
	typedef logic [`WORD_W-1:0] trig_rec_t;

	// round robin pointer over the channels
	typedef logic [$clog2(`NCHAN)-1:0] chan_idx_t;

endpackage

`default_nettype wire

//--- hdl/stream_if.sv
`default_nettype none

`include "chan_config.svh"

// valid/ready stream, transfer on an edge with both high
interface stream_if;
	logic                valid;
	logic                ready;
	logic [`WORD_W-1:0]  data;
	logic                k;      // trigger word marker

	// fifo side
	modport src (output valid, output data, output k, input ready);
	// arbiter side
	modport snk (input valid, input data, input k, output ready);
endinterface

`default_nettype wire

//--- hdl/par_regs.sv
`default_nettype none

`include "chan_config.svh"

module par_regs (
	input  wire logic                   wb_clk,
	input  wire logic                   rst_n_i,
	input  wire logic                   reg_we_i,
	input  wire logic [`REG_ADR_W-1:0]  reg_adr_i,
	input  wire logic [`WORD_W-1:0]     reg_dat_i,
	output logic [`WORD_W-1:0]          reg_dat_o,
	output chan_pkg::diff_t             zthr_o,
	output chan_pkg::word_t             sthr_o,
	output logic [`NCHAN-1:0]           mask_o,
	output logic [`NCHAN-1:0]           inv_o,
	output chan_pkg::sample_t           ped_o [`NCHAN],
	input  wire logic [`NCHAN:0]        ovf_i     // drop pulses, trigger fifo on top
);

	logic [`NCHAN:0]  stat_q;   // sticky drop flags
	logic             rd_stat;
	chan_pkg::word_t  rd_val;

	assign rd_stat = (reg_adr_i == `REG_ADR_W'(`REG_STAT));

	////////////////////////////////////////////////////////////////////////////
	// read-back mux
	always_comb begin
		rd_val = '0;
		case (reg_adr_i)
			`REG_ZTHR: rd_val = chan_pkg::word_t'(zthr_o);   // sign extended
			`REG_STHR: rd_val = sthr_o;
			`REG_MASK: rd_val[`NCHAN-1:0] = mask_o;
			`REG_INV:  rd_val[`NCHAN-1:0] = inv_o;
			`REG_STAT: rd_val[`NCHAN:0] = stat_q;
			default:   rd_val = '0;
		endcase
		// pedestal block
		for (int n = 0; n < `NCHAN; n++) begin
			if (reg_adr_i == `REG_ADR_W'(`REG_PED0 + n))
				rd_val = chan_pkg::word_t'(ped_o[n]);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// writes, status and registered read data
	always_ff @(posedge wb_clk) begin
		if (!rst_n_i) begin
			zthr_o    <= '0;
			sthr_o    <= '0;
			mask_o    <= '0;
			inv_o     <= '0;
			stat_q    <= '0;
			reg_dat_o <= '0;
			for (int n = 0; n < `NCHAN; n++)
				ped_o[n] <= '0;
		end else begin
			if (reg_we_i) begin
				case (reg_adr_i)
					`REG_ZTHR: zthr_o <= reg_dat_i[`SMP_W:0];
					`REG_STHR: sthr_o <= reg_dat_i;
					`REG_MASK: mask_o <= reg_dat_i[`NCHAN-1:0];
					`REG_INV:  inv_o  <= reg_dat_i[`NCHAN-1:0];
					default: ;  // status is read only
				endcase
				for (int n = 0; n < `NCHAN; n++) begin
					if (reg_adr_i == `REG_ADR_W'(`REG_PED0 + n))
						ped_o[n] <= reg_dat_i[`SMP_W-1:0];
				end
			end
			// a drop in the read cycle survives the clear
			stat_q    <= (rd_stat ? '0 : stat_q) | ovf_i;
			reg_dat_o <= rd_val;
		end
	end

endmodule

`default_nettype wire

//--- hdl/chan_proc.sv
`default_nettype none

`include "chan_config.svh"

module chan_proc #(
	parameter int CHAN_NUM = 0                // tag put into every word
) (
	input  wire logic               wb_clk,
	input  wire logic               rst_n_i,
	input  wire logic               smp_vld_i,
	input  wire chan_pkg::sample_t  smp_i,
	input  wire chan_pkg::sample_t  ped_i,
	input  wire chan_pkg::diff_t    zthr_i,
	input  wire logic               mask_i,
	input  wire logic               inv_i,
	output chan_pkg::diff_t         diff_o,    // to the sum, zero when masked out
	output logic                    push_o,    // word passes zero suppression
	output chan_pkg::chan_word_t    word_o
);

	chan_pkg::diff_t  diff_c;    // unregistered difference
	chan_pkg::diff_t  diff_q;
	logic             vld_q;     // diff_q is fresh this cycle
	logic             en_q;      // mask bit taken with the sample

	////////////////////////////////////////////////////////////////////////////
	// pedestal subtraction

	// both operands zero extended, result fits 13 bits signed
	always_comb begin
		if (inv_i)
			diff_c = $signed({1'b0, ped_i}) - $signed({1'b0, smp_i});   // negative pulses
		else
			diff_c = $signed({1'b0, smp_i}) - $signed({1'b0, ped_i});
	end

	always_ff @(posedge wb_clk) begin
		if (!rst_n_i) begin
			vld_q <= 1'b0;
			en_q  <= 1'b0;
		end else begin
			vld_q <= smp_vld_i;              // one cycle strobe
			if (smp_vld_i)
				en_q <= mask_i;
		end
	end

	// payload, only loaded with a sample
	always_ff @(posedge wb_clk) begin
		if (smp_vld_i)
			diff_q <= mask_i ? diff_c : '0;  // masked channel adds nothing
	end

	////////////////////////////////////////////////////////////////////////////
	// zero suppression and tagging

	assign diff_o = diff_q;

	// signed compare, threshold taken live from the register
	assign push_o = vld_q & en_q & (diff_q > zthr_i);

	assign word_o = '{chan: 3'(CHAN_NUM), diff: diff_q};

endmodule

`default_nettype wire

//--- hdl/evt_fifo.sv
`default_nettype none

`include "chan_config.svh"

module evt_fifo #(
	parameter type T     = chan_pkg::chan_word_t,   // payload, one stream word wide
	parameter int  DEPTH = 8
) (
	input  wire logic  wb_clk,
	input  wire logic  rst_n_i,
	input  wire logic  push_i,
	input  wire T      din_i,
	output logic       ovf_o,    // push dropped, one cycle
	stream_if.src      out       // head of the fifo, k comes from the top
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T                    mem [DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [PTR_W:0]      cnt;       // words stored
	logic                full;
	logic                wr;
	logic                rd;

	assign full  = (cnt == (PTR_W+1)'(DEPTH));
	assign wr    = push_i & ~full;
	assign rd    = out.valid & out.ready;   // pop on transfer
	assign ovf_o = push_i & full;

	always_ff @(posedge wb_clk) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			if (wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			cnt <= cnt + (PTR_W+1)'(wr) - (PTR_W+1)'(rd);
		end
	end

	// storage, no reset
	always_ff @(posedge wb_clk) begin
		if (wr)
			mem[wr_ptr] <= din_i;
	end

	// head stays put until popped
	assign out.valid = (cnt != '0);
	assign out.data  = chan_pkg::word_t'(mem[rd_ptr]);

endmodule

`default_nettype wire

//--- hdl/sum_trig.sv
`default_nettype none

`include "chan_config.svh"

module sum_trig (
	input  wire logic              wb_clk,
	input  wire logic              rst_n_i,
	input  wire logic              diff_vld_i,          // strobe of the sample behind diff_i
	input  wire chan_pkg::diff_t   diff_i [`NCHAN],     // arrive one cycle after the strobe
	input  wire chan_pkg::word_t   sthr_i,
	input  wire logic              smp_vld_i,           // counts samples
	output logic                   push_o,
	output chan_pkg::trig_rec_t    rec_o
);

	localparam int SUM_W = `SMP_W + 1 + $clog2(`NCHAN);   // no overflow on full scale

	chan_pkg::trig_rec_t        cnt_q;    // samples since reset
	chan_pkg::trig_rec_t        ts_d1;
	chan_pkg::trig_rec_t        ts_d2;
	logic                       vld_d1;   // diffs valid
	logic                       vld_d2;   // sum valid
	logic signed [SUM_W-1:0]    acc;
	logic signed [SUM_W-1:0]    sum_q;
	logic signed [`WORD_W-1:0]  sum_ext;
	logic                       above;
	logic                       above_q;  // result of previous sum

	// adder tree, masked channels come in as zero
	always_comb begin
		acc = '0;
		for (int n = 0; n < `NCHAN; n++)
			acc = acc + SUM_W'(diff_i[n]);
	end

	assign sum_ext = `WORD_W'(sum_q);
	assign above   = sum_ext > $signed(sthr_i);

	always_ff @(posedge wb_clk) begin
		if (!rst_n_i) begin
			cnt_q   <= '0;
			vld_d1  <= 1'b0;
			vld_d2  <= 1'b0;
			above_q <= 1'b0;
		end else begin
			if (smp_vld_i)
				cnt_q <= cnt_q + 1'b1;
			vld_d1 <= diff_vld_i;
			vld_d2 <= vld_d1;
			if (vld_d2)
				above_q <= above;
		end
	end

	// sum and timestamp follow the same pipe
	always_ff @(posedge wb_clk) begin
		if (diff_vld_i)
			ts_d1 <= cnt_q;          // count before this sample
		if (vld_d1) begin
			sum_q <= acc;
			ts_d2 <= ts_d1;
		end
	end

	// rising crossing only
	assign push_o = vld_d2 & above & ~above_q;
	assign rec_o  = ts_d2;

endmodule

`default_nettype wire

//--- hdl/send_arb.sv
`default_nettype none

`include "chan_config.svh"

module send_arb (
	input  wire logic        wb_clk,
	input  wire logic        rst_n_i,
	stream_if.snk            trig,              // strict priority
	stream_if.snk            chan [`NCHAN],     // round robin
	output chan_pkg::word_t  tx_dat_o,
	output logic             tx_k_o,
	output logic             tx_vld_o,
	input  wire logic        tx_rdy_i
);

	logic [`NCHAN-1:0]   c_vld;
	logic [`NCHAN-1:0]   c_k;
	logic [`NCHAN-1:0]   c_rdy;
	chan_pkg::word_t     c_dat [`NCHAN];
	chan_pkg::chan_idx_t rr_q;       // last channel served
	chan_pkg::chan_idx_t sel;
	logic                found;
	logic                load;       // output register free or draining

	////////////////////////////////////////////////////////////////////////////
	// flatten the interface array
	for (genvar g = 0; g < `NCHAN; g++) begin : g_chan
		assign c_vld[g]      = chan[g].valid;
		assign c_dat[g]      = chan[g].data;
		assign c_k[g]        = chan[g].k;
		assign chan[g].ready = c_rdy[g];
	end

	assign load = ~tx_vld_o | tx_rdy_i;

	// next channel with data after the last one served
	always_comb begin
		chan_pkg::chan_idx_t idx;
		found = 1'b0;
		sel   = rr_q;
		for (int i = 1; i <= `NCHAN; i++) begin
			idx = chan_pkg::chan_idx_t'((int'(rr_q) + i) % `NCHAN);
			if (!found && c_vld[idx]) begin
				found = 1'b1;
				sel   = idx;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pops, one source per cycle
	assign trig.ready = load;
	always_comb begin
		for (int n = 0; n < `NCHAN; n++)
			c_rdy[n] = load & ~trig.valid & found & (sel == chan_pkg::chan_idx_t'(n));
	end

	// output register
	always_ff @(posedge wb_clk) begin
		if (!rst_n_i) begin
			tx_vld_o <= 1'b0;
			tx_k_o   <= 1'b0;
			rr_q     <= '0;
		end else if (load) begin
			tx_vld_o <= trig.valid | found;
			if (trig.valid)
				tx_k_o <= trig.k;               // trigger words carry k
			else
				tx_k_o <= found & c_k[sel];
			if (!trig.valid && found)
				rr_q <= sel;                    // advance only on a channel grant
		end
	end

	// payload, no reset
	always_ff @(posedge wb_clk) begin
		if (load)
			tx_dat_o <= trig.valid ? trig.data : c_dat[sel];
	end

endmodule

`default_nettype wire

//--- hdl/chan_top.sv
`default_nettype none

`include "chan_config.svh"

module chan_top (
	input  wire logic                       wb_clk,
	input  wire logic                       rst_n_i,
	// register port
	input  wire logic                       reg_we_i,
	input  wire logic [`REG_ADR_W-1:0]      reg_adr_i,
	input  wire logic [`WORD_W-1:0]         reg_dat_i,
	output logic [`WORD_W-1:0]              reg_dat_o,
	// samples, channel 0 in the low bits
	input  wire logic                       adc_vld_i,
	input  wire logic [`NCHAN*`SMP_W-1:0]   adc_dat_i,
	// output stream
	output logic [`WORD_W-1:0]              tx_dat_o,
	output logic                            tx_k_o,
	output logic                            tx_vld_o,
	input  wire logic                       tx_rdy_i
);

	chan_pkg::diff_t       zthr;
	chan_pkg::word_t       sthr;
	logic [`NCHAN-1:0]     mask;
	logic [`NCHAN-1:0]     inv;
	chan_pkg::sample_t     ped [`NCHAN];
	logic [`NCHAN:0]       ovf;         // fifo drops, trigger on top
	chan_pkg::diff_t       diff [`NCHAN];
	logic [`NCHAN-1:0]     push;
	chan_pkg::chan_word_t  cword [`NCHAN];
	logic                  trig_push;
	chan_pkg::trig_rec_t   trig_rec;

	stream_if chan_s [`NCHAN] ();
	stream_if trig_s ();

	assign trig_s.k = 1'b1;             // only the trigger stream is marked

	////////////////////////////////////////////////////////////////////////////
	par_regs par_regs_i (
		.wb_clk    (wb_clk),
		.rst_n_i   (rst_n_i),
		.reg_we_i  (reg_we_i),
		.reg_adr_i (reg_adr_i),
		.reg_dat_i (reg_dat_i),
		.reg_dat_o (reg_dat_o),
		.zthr_o    (zthr),
		.sthr_o    (sthr),
		.mask_o    (mask),
		.inv_o     (inv),
		.ped_o     (ped),
		.ovf_i     (ovf)
	);

	////////////////////////////////////////////////////////////////////////////
	// per channel path
	for (genvar g = 0; g < `NCHAN; g++) begin : g_chan
		assign chan_s[g].k = 1'b0;

		chan_proc #(.CHAN_NUM(g)) chan_proc_i (
			.wb_clk    (wb_clk),
			.rst_n_i   (rst_n_i),
			.smp_vld_i (adc_vld_i),
			.smp_i     (adc_dat_i[g*`SMP_W +: `SMP_W]),
			.ped_i     (ped[g]),
			.zthr_i    (zthr),
			.mask_i    (mask[g]),
			.inv_i     (inv[g]),
			.diff_o    (diff[g]),
			.push_o    (push[g]),
			.word_o    (cword[g])
		);

		evt_fifo #(.T(chan_pkg::chan_word_t), .DEPTH(`CHAN_FIFO_DEPTH)) chan_fifo_i (
			.wb_clk  (wb_clk),
			.rst_n_i (rst_n_i),
			.push_i  (push[g]),
			.din_i   (cword[g]),
			.ovf_o   (ovf[g]),
			.out     (chan_s[g])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// sum trigger and its fifo
	sum_trig sum_trig_i (
		.wb_clk     (wb_clk),
		.rst_n_i    (rst_n_i),
		.diff_vld_i (adc_vld_i),
		.diff_i     (diff),
		.sthr_i     (sthr),
		.smp_vld_i  (adc_vld_i),
		.push_o     (trig_push),
		.rec_o      (trig_rec)
	);

	evt_fifo #(.T(chan_pkg::trig_rec_t), .DEPTH(`TRIG_FIFO_DEPTH)) trig_fifo_i (
		.wb_clk  (wb_clk),
		.rst_n_i (rst_n_i),
		.push_i  (trig_push),
		.din_i   (trig_rec),
		.ovf_o   (ovf[`NCHAN]),
		.out     (trig_s)
	);

	send_arb send_arb_i (
		.wb_clk   (wb_clk),
		.rst_n_i  (rst_n_i),
		.trig     (trig_s),
		.chan     (chan_s),
		.tx_dat_o (tx_dat_o),
		.tx_k_o   (tx_k_o),
		.tx_vld_o (tx_vld_o),
		.tx_rdy_i (tx_rdy_i)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`default_nettype none

// free running clock and a short synchronous reset
module tb_clk_gen (
	output logic  wb_clk,
	output logic  rst_n_o
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		wb_clk = 1'b0;
		forever #20 wb_clk = ~wb_clk;    // 40 ns period
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (2) @(posedge wb_clk);    // two edges in reset
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/chan_top_props.sv
`default_nettype none

`include "chan_config.svh"

// output stream protocol, bound into chan_top
module chan_top_props (
	input  wire logic                wb_clk,
	input  wire logic                rst_n_i,
	input  wire logic [`WORD_W-1:0]  tx_dat_i,
	input  wire logic                tx_k_i,
	input  wire logic                tx_vld_i,
	input  wire logic                tx_rdy_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned err_cnt = 0;    // read by the testbench top

	// output register empty once reset is seen
	a_rst_idle: assert property (@(posedge wb_clk) !rst_n_i |=> !tx_vld_i)
		else begin
			$error("tx_vld_o high in the cycle after reset");
			err_cnt++;
		end

	// a stalled word stays put until taken
	a_hold: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
		tx_vld_i && !tx_rdy_i |=> tx_vld_i && $stable(tx_dat_i) && $stable(tx_k_i))
		else begin
			$error("output stream changed while tx_rdy_i was low");
			err_cnt++;
		end

	// k marks trigger words only, never an idle cycle
	a_k_vld: assert property (@(posedge wb_clk) disable iff (!rst_n_i) tx_k_i |-> tx_vld_i)
		else begin
			$error("tx_k_o high without tx_vld_o");
			err_cnt++;
		end

endmodule

bind chan_top chan_top_props props_i (
	.wb_clk   (wb_clk),
	.rst_n_i  (rst_n_i),
	.tx_dat_i (tx_dat_o),
	.tx_k_i   (tx_k_o),
	.tx_vld_i (tx_vld_o),
	.tx_rdy_i (tx_rdy_i)
);

`default_nettype wire

//--- testbench/tb_chan_top.sv
`default_nettype none

`include "chan_config.svh"

module tb_chan_top;
	timeunit 1ns;
	timeprecision 1ps;

	logic                       wb_clk;
	logic                       rst_n;
	logic                       reg_we  = 1'b0;
	logic [`REG_ADR_W-1:0]      reg_adr = '0;
	logic [`WORD_W-1:0]         reg_dat = '0;
	logic [`WORD_W-1:0]         reg_rd;
	logic                       adc_vld = 1'b0;
	logic [`NCHAN*`SMP_W-1:0]   adc_dat = '0;
	logic [`WORD_W-1:0]         tx_dat;
	logic                       tx_k;
	logic                       tx_vld;
	logic                       tx_rdy  = 1'b0;

	// reference model, mirrors the register map
	int                         m_zthr  = 0;
	int                         m_sthr  = 0;
	logic [`NCHAN-1:0]          m_mask  = '0;
	logic [`NCHAN-1:0]          m_inv   = '0;
	logic [`SMP_W-1:0]          m_ped [`NCHAN];
	logic                       m_above = 1'b0;   // last sum over threshold
	logic [`WORD_W-1:0]         smp_cnt = '0;     // samples since reset
	logic [`WORD_W-1:0]         chan_q [`NCHAN][$];
	logic [`WORD_W-1:0]         trig_q [$];

	string                      cur_test = "reset";
	int                         test_err  = 0;
	int                         total_err = 0;
	int                         n_tests   = 0;
	int                         n_failed  = 0;
	int                         n_words   = 0;
	logic                       check_en  = 1'b1;
	int                         rdy_mode  = 1;    // 0 low, 1 high, 2 random
	logic [31:0]                rng       = 32'd17038;
	logic [31:0]                rdy_rng   = 32'd17038;

	tb_clk_gen clk_gen_i (
		.wb_clk  (wb_clk),
		.rst_n_o (rst_n)
	);

	chan_top chan_top_i (
		.wb_clk    (wb_clk),
		.rst_n_i   (rst_n),
		.reg_we_i  (reg_we),
		.reg_adr_i (reg_adr),
		.reg_dat_i (reg_dat),
		.reg_dat_o (reg_rd),
		.adc_vld_i (adc_vld),
		.adc_dat_i (adc_dat),
		.tx_dat_o  (tx_dat),
		.tx_k_o    (tx_k),
		.tx_vld_o  (tx_vld),
		.tx_rdy_i  (tx_rdy)
	);

	////////////////////////////////////////////////////////////////////////////
	// random numbers

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic logic [`NCHAN*`SMP_W-1:0] rand_samples();
		logic [`NCHAN*`SMP_W-1:0] s;
		logic [31:0]              r;
		for (int n = 0; n < `NCHAN; n++) begin
			r = next_rand();
			s[n*`SMP_W +: `SMP_W] = r[`SMP_W-1:0];
		end
		return s;
	endfunction

	// output ready pattern, the only driver of tx_rdy
	always @(posedge wb_clk) begin
		rdy_rng = xorshift(rdy_rng);
		case (rdy_mode)
			0:       tx_rdy <= 1'b0;
			1:       tx_rdy <= 1'b1;
			default: tx_rdy <= rdy_rng[7];
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// register port

	function automatic logic [`WORD_W-1:0] reg_expect(input int adr);
		logic [`WORD_W-1:0] v;
		v = '0;
		case (adr)
			`REG_ZTHR: v = `WORD_W'(m_zthr);    // 13 bit value sign extended
			`REG_STHR: v = `WORD_W'(m_sthr);
			`REG_MASK: v[`NCHAN-1:0] = m_mask;
			`REG_INV:  v[`NCHAN-1:0] = m_inv;
			default: begin
				if (adr >= `REG_PED0 && adr < `REG_PED0 + `NCHAN)
					v = `WORD_W'(m_ped[adr - `REG_PED0]);
			end
		endcase
		return v;
	endfunction

	task automatic write_reg(input int adr, input logic [`WORD_W-1:0] dat);
		@(posedge wb_clk);
		reg_we  <= 1'b1;
		reg_adr <= `REG_ADR_W'(adr);
		reg_dat <= dat;
		@(posedge wb_clk);
		reg_we  <= 1'b0;
		case (adr)
			`REG_ZTHR: m_zthr = int'($signed(dat[`SMP_W:0]));
			`REG_STHR: m_sthr = int'($signed(dat));
			`REG_MASK: m_mask = dat[`NCHAN-1:0];
			`REG_INV:  m_inv  = dat[`NCHAN-1:0];
			default: begin
				if (adr >= `REG_PED0 && adr < `REG_PED0 + `NCHAN)
					m_ped[adr - `REG_PED0] = dat[`SMP_W-1:0];
			end
		endcase
	endtask

	// address for one edge, data one cycle later
	task automatic check_reg(input int adr, input logic [`WORD_W-1:0] exp);
		logic [`WORD_W-1:0] got;
		@(posedge wb_clk);
		reg_adr <= `REG_ADR_W'(adr);
		@(posedge wb_clk);
		reg_adr <= '0;                  // off REG_STAT, no second clear
		@(negedge wb_clk);
		got = reg_rd;
		assert (got == exp) else begin
			$display("[FAIL] %s reg %0d expected %h actual %h", cur_test, adr, exp, got);
			test_err++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// samples and the model of the channel path

	task automatic send_sample(input logic [`NCHAN*`SMP_W-1:0] smp, input int gap);
		int                 d;
		int                 sum;
		logic               above;
		logic [`SMP_W-1:0]  raw;
		sum = 0;
		for (int n = 0; n < `NCHAN; n++) begin
			raw = smp[n*`SMP_W +: `SMP_W];
			d = m_inv[n] ? int'(m_ped[n]) - int'(raw) : int'(raw) - int'(m_ped[n]);
			if (m_mask[n]) begin
				sum += d;                      // masked out adds nothing
				if (d > m_zthr)
					chan_q[n].push_back({3'(n), 13'(d)});
			end
		end
		above = (sum > m_sthr);
		if (above && !m_above)
			trig_q.push_back(smp_cnt);     // rising crossing only
		m_above = above;
		smp_cnt++;
		@(posedge wb_clk);
		adc_vld <= 1'b1;
		adc_dat <= smp;
		@(posedge wb_clk);
		adc_vld <= 1'b0;
		repeat (gap) @(posedge wb_clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// output checker

	function automatic logic queues_empty();
		logic e;
		e = (trig_q.size() == 0);
		for (int n = 0; n < `NCHAN; n++)
			e &= (chan_q[n].size() == 0);
		return e;
	endfunction

	task automatic check_word(input logic [`WORD_W-1:0] dat, input logic k);
		int                 c;
		logic [`WORD_W-1:0] exp;
		n_words++;
		if (k) begin
			assert (trig_q.size() > 0) else begin
				$display("unexpected trigger word %h in test %s", dat, cur_test);
				test_err++;
			end
			if (trig_q.size() > 0) begin
				exp = trig_q.pop_front();
				assert (dat == exp) else begin
					$display("[FAIL] %s trigger expected %h actual %h", cur_test, exp, dat);
					test_err++;
				end
			end
		end else begin
			c = int'(dat[`WORD_W-1:`SMP_W+1]);   // channel tag
			assert (c < `NCHAN && chan_q[c].size() > 0) else begin
				$display("unexpected channel word %h in test %s", dat, cur_test);
				test_err++;
			end
			if (c < `NCHAN && chan_q[c].size() > 0) begin
				exp = chan_q[c].pop_front();
				assert (dat == exp) else begin
					$display("[FAIL] %s chan %0d expected %h actual %h", cur_test, c, exp, dat);
					test_err++;
				end
			end
		end
	endtask

	// transfer at the coming edge, values stable at the falling one
	always @(negedge wb_clk) begin
		if (rst_n && check_en && tx_vld && tx_rdy)
			check_word(tx_dat, tx_k);
	end

	// all expected words out and the stream quiet for a few cycles
	task automatic wait_drain();
		int t;
		int quiet;
		t = 0;
		quiet = 0;
		while (quiet < 4 && t < 2000) begin
			@(negedge wb_clk);
			t++;
			if (!tx_vld && queues_empty())
				quiet++;
			else
				quiet = 0;
		end
		if (quiet < 4) begin
			$display("timeout: output stream did not drain in test %s", cur_test);
			test_err++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_err = 0;
	endtask

	task automatic end_test();
		n_tests++;
		total_err += test_err;
		if (test_err != 0)
			n_failed++;
		$display("test %-14s %s, %0d errors", cur_test, (test_err == 0) ? "ok" : "bad", test_err);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		logic [31:0]              r;
		logic [`NCHAN*`SMP_W-1:0] smp;
		int                       t;
		for (int n = 0; n < `NCHAN; n++)
			m_ped[n] = '0;
		t = 0;
		while (!rst_n && t < 10) begin
			@(negedge wb_clk);
			t++;
		end
		if (!rst_n) begin
			$display("timeout: reset was never released");
			total_err++;
		end

		// 1 every address written and read back
		begin_test("reg_rw");
		check_reg(`REG_STAT, '0);
		for (int a = 0; a < (1 << `REG_ADR_W); a++) begin
			r = next_rand();
			write_reg(a, r[`WORD_W-1:0]);
		end
		for (int a = 0; a < (1 << `REG_ADR_W); a++)
			check_reg(a, reg_expect(a));
		end_test();

		// 2 random data, all channels in
		begin_test("zero_supp");
		write_reg(`REG_MASK, 16'h000f);
		write_reg(`REG_INV, 16'h0000);
		write_reg(`REG_ZTHR, 16'd40);
		write_reg(`REG_STHR, 16'h7fff);    // out of reach, no triggers
		for (int n = 0; n < `NCHAN; n++) begin
			r = next_rand();
			write_reg(`REG_PED0 + n, {4'h0, r[`SMP_W-1:0]});
		end
		repeat (40) send_sample(rand_samples(), 3);
		wait_drain();
		check_reg(`REG_STAT, '0);
		end_test();

		// 3 inverted and masked channels, negative threshold
		begin_test("inv_mask");
		write_reg(`REG_MASK, 16'h0006);
		write_reg(`REG_INV, 16'h000a);
		write_reg(`REG_ZTHR, 16'(-200));
		write_reg(`REG_STHR, 16'h0000);    // sum crossings now matter
		repeat (40) send_sample(rand_samples(), 3);
		wait_drain();
		end_test();

		// 4 steps of the sum across the threshold
		begin_test("sum_trig");
		write_reg(`REG_MASK, 16'h000f);
		write_reg(`REG_INV, 16'h0000);
		write_reg(`REG_ZTHR, 16'h0fff);    // no channel words
		write_reg(`REG_STHR, 16'd1000);
		for (int n = 0; n < `NCHAN; n++)
			write_reg(`REG_PED0 + n, 16'd100);
		repeat (3) send_sample({`NCHAN{12'd100}}, 3);
		repeat (4) send_sample({`NCHAN{12'd500}}, 3);   // one k word, then nothing
		repeat (2) send_sample({`NCHAN{12'd100}}, 3);
		repeat (3) send_sample({`NCHAN{12'd500}}, 3);
		wait_drain();
		end_test();

		// 5 random stalls on the output
		begin_test("back_pressure");
		rdy_mode = 2;
		write_reg(`REG_ZTHR, 16'd1000);
		write_reg(`REG_STHR, 16'd4000);
		for (int n = 0; n < `NCHAN; n++) begin
			r = next_rand();
			write_reg(`REG_PED0 + n, {4'h0, r[`SMP_W-1:0]});
		end
		repeat (60) send_sample(rand_samples(), 5);
		wait_drain();
		check_reg(`REG_STAT, '0);        // nothing dropped
		rdy_mode = 1;
		end_test();

		// 6 channel 0 fifo overrun with the output stalled
		begin_test("overflow");
		rdy_mode = 0;
		check_en = 1'b0;
		write_reg(`REG_MASK, 16'h0001);
		write_reg(`REG_ZTHR, 16'h0000);
		write_reg(`REG_STHR, 16'h7fff);
		write_reg(`REG_PED0, 16'h0000);
		for (int i = 0; i < `CHAN_FIFO_DEPTH + 4; i++) begin
			smp = rand_samples();
			smp[`SMP_W-1:0] = `SMP_W'(100 + i);
			send_sample(smp, 1);
		end
		check_reg(`REG_STAT, 16'h0001);
		check_reg(`REG_STAT, '0);        // cleared by the first read
		for (int n = 0; n < `NCHAN; n++)
			chan_q[n].delete();
		trig_q.delete();
		rdy_mode = 1;
		wait_drain();
		check_en = 1'b1;
		end_test();

		total_err += int'(chan_top_i.props_i.err_cnt);
		$display("tests %0d, failed %0d, words checked %0d, errors %0d",
			n_tests, n_failed, n_words, total_err);
		if (total_err == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/chan_pkg.sv
hdl/stream_if.sv
hdl/par_regs.sv
hdl/chan_proc.sv
hdl/evt_fifo.sv
hdl/sum_trig.sv
hdl/send_arb.sv
hdl/chan_top.sv
testbench/tb_clk_gen.sv
testbench/chan_top_props.sv
testbench/tb_chan_top.sv

//--- run.sh
#!/bin/sh
# build tb_chan_top with Verilator, run it, decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_chan_top -f list.f \
	-Mdir obj_dir -o tb_chan_top > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_chan_top +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1
